// ==== filelist.f ====
common/uart_axi_pkg.sv
hdl/byte_fifo.sv
axi_lite/axi_lite_slave.sv
hdl/uart_regfile.sv
hdl/uart_axi_top.sv
tb/axi_lite_slave_asserts.sv
tb/tb_uart_axi.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the UART register block testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_uart_axi -f filelist.f -o sim_uart \
	&& ./obj_dir/sim_uart > sim.log 2>&1 \
	|| echo "build or simulation returned an error"

grep -qx "STATUS: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/tb_uart_axi.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_uart_axi;

	localparam int TIMEOUT = 100; // cycles per wait

	localparam logic [2:0] OP_WR   = 3'd0; // bus write
	localparam logic [2:0] OP_RD   = 3'd1; // bus read, exp is the read word
	localparam logic [2:0] OP_TX   = 3'd2; // check tx_o, then one t_done pulse
	localparam logic [2:0] OP_RX   = 3'd3; // one r_done pulse with rx_i = data
	localparam logic [2:0] OP_PINS = 3'd4; // exp is {tx_en, rx_en, baud_div}

	localparam logic [31:0] A_CTRL   = 32'h2000_0000;
	localparam logic [31:0] A_STATUS = 32'h2000_0004;
	localparam logic [31:0] A_RDATA  = 32'h2000_0008;
	localparam logic [31:0] A_WDATA  = 32'h2000_000C;
	localparam logic [31:0] A_OUTSIDE = 32'h2000_0010; // first word past the window

	typedef struct packed {
		logic [2:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] exp;
	} step_t;

	logic        clk;
	logic        aresetn;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic        rvalid;
	logic        rready;
	logic        t_done;
	logic        r_done;
	logic [7:0]  rx_data;
	logic        tx_en;
	logic        rx_en;
	logic [7:0]  tx_data;
	logic [15:0] baud_div;

	step_t steps[$];
	int    errors;
	logic  hung; // some wait ran out

	uart_axi_top #(.FIFO_DEPTH(32)) dut0 (
		.s_axi_aclk_i    (clk),
		.s_axi_aresetn_i (aresetn),
		.s_axi_awaddr_i  (awaddr),
		.s_axi_awvalid_i (awvalid),
		.s_axi_awready_o (awready),
		.s_axi_wdata_i   (wdata),
		.s_axi_wstrb_i   (wstrb),
		.s_axi_wvalid_i  (wvalid),
		.s_axi_wready_o  (wready),
		.s_axi_bvalid_o  (bvalid),
		.s_axi_bready_i  (bready),
		.s_axi_araddr_i  (araddr),
		.s_axi_arvalid_i (arvalid),
		.s_axi_arready_o (arready),
		.s_axi_rdata_o   (rdata),
		.s_axi_rvalid_o  (rvalid),
		.s_axi_rready_i  (rready),
		.t_done_i        (t_done),
		.r_done_i        (r_done),
		.rx_i            (rx_data),
		.tx_en_o         (tx_en),
		.rx_en_o         (rx_en),
		.tx_o            (tx_data),
		.baud_div_o      (baud_div)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// starts and ends on a falling edge, response held one cycle before bready
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int cnt;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		cnt = 0;
		while (!(awready && wready) && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!(awready && wready)) begin
			$display("timeout: write to %h was never accepted", addr);
			hung = 1'b1;
		end else begin
			@(negedge clk); // accepted on the edge just passed
			awvalid = 1'b0;
			wvalid  = 1'b0;
			cnt = 0;
			while (!bvalid && cnt < TIMEOUT) begin
				@(negedge clk);
				cnt++;
			end
			if (!bvalid) begin
				$display("timeout: no write response for %h", addr);
				hung = 1'b1;
			end else begin
				@(negedge clk); // one cycle of back-pressure
				compare_word("s_axi_bvalid_o", {31'd0, bvalid}, 32'd1);
				compare_word("s_axi_awready_o", {31'd0, awready}, 32'd0);
				compare_word("s_axi_wready_o", {31'd0, wready}, 32'd0);
				bready = 1'b1;
				@(negedge clk);
				bready = 1'b0;
			end
		end
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		int cnt;
		araddr  = addr;
		arvalid = 1'b1;
		data    = 32'd0;
		cnt = 0;
		while (!arready && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!arready) begin
			$display("timeout: read of %h was never accepted", addr);
			hung = 1'b1;
		end else begin
			@(negedge clk);
			arvalid = 1'b0;
			cnt = 0;
			while (!rvalid && cnt < TIMEOUT) begin
				@(negedge clk);
				cnt++;
			end
			if (!rvalid) begin
				$display("timeout: no read data for %h", addr);
				hung = 1'b1;
			end else begin
				@(negedge clk); // data must hold while rready is low
				compare_word("s_axi_rvalid_o", {31'd0, rvalid}, 32'd1);
				compare_word("s_axi_arready_o", {31'd0, arready}, 32'd0);
				data   = rdata;
				rready = 1'b1;
				@(negedge clk);
				rready = 1'b0;
			end
		end
	endtask

	function automatic void add_step(input logic [2:0] op, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input logic [31:0] exp);
		steps.push_back({op, addr, data, strb, exp});
	endfunction

	task automatic build_table();
		// reset values
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_000A);
		add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 32'h0000_0000);
		add_step(OP_RD, A_CTRL, 32'd0, 4'h0, 32'h0000_0000);
		// byte strobes on ctrl
		add_step(OP_WR, A_CTRL, 32'h1234_5678, 4'hC, 32'd0);
		add_step(OP_RD, A_CTRL, 32'd0, 4'h0, 32'h1234_0000);
		add_step(OP_WR, A_CTRL, 32'h9999_00F0, 4'h3, 32'd0);
		add_step(OP_RD, A_CTRL, 32'd0, 4'h0, 32'h1234_00F0);
		add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 32'h0000_1234);
		// three bytes out through the serializer
		add_step(OP_WR, A_CTRL, 32'h0000_0001, 4'h1, 32'd0);
		add_step(OP_WR, A_WDATA, 32'h0000_0041, 4'hF, 32'd0);
		add_step(OP_WR, A_WDATA, 32'h0000_0042, 4'hF, 32'd0);
		add_step(OP_WR, A_WDATA, 32'h0000_0043, 4'hF, 32'd0);
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_0008);
		add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 32'h0002_1234);
		add_step(OP_TX, 32'd0, 32'd0, 4'h0, 32'h0000_0041);
		add_step(OP_TX, 32'd0, 32'd0, 4'h0, 32'h0000_0042);
		add_step(OP_TX, 32'd0, 32'd0, 4'h0, 32'h0000_0043);
		add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 32'h0000_1234); // tx_en low once empty
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_000A);
		// three bytes in
		add_step(OP_WR, A_CTRL, 32'h0000_0002, 4'h1, 32'd0);
		add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 32'h0001_1234);
		add_step(OP_RX, 32'd0, 32'h0000_005A, 4'h0, 32'd0);
		add_step(OP_RX, 32'd0, 32'h0000_00C3, 4'h0, 32'd0);
		add_step(OP_RX, 32'd0, 32'h0000_0007, 4'h0, 32'd0);
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_0002);
		add_step(OP_RD, A_RDATA, 32'd0, 4'h0, 32'h0000_005A);
		add_step(OP_RD, A_RDATA, 32'd0, 4'h0, 32'h0000_00C3);
		add_step(OP_RD, A_RDATA, 32'd0, 4'h0, 32'h0000_0007);
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_000A);
		add_step(OP_RD, A_RDATA, 32'd0, 4'h0, 32'h0000_0000); // empty reads zero
		// fill tx with the serializer off so the 33rd byte is dropped
		add_step(OP_WR, A_CTRL, 32'h0000_0000, 4'h1, 32'd0);
		for (int i = 0; i < 33; i++) begin
			add_step(OP_WR, A_WDATA, {24'd0, 8'(i * 29 + 7)}, 4'hF, 32'd0);
		end
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_0009);
		add_step(OP_WR, A_CTRL, 32'h0000_0001, 4'h1, 32'd0);
		for (int i = 0; i < 32; i++) begin
			add_step(OP_TX, 32'd0, 32'd0, 4'h0, {24'd0, 8'(i * 29 + 7)});
		end
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_000A);
		// just past the window
		add_step(OP_WR, A_OUTSIDE, 32'hFFFF_FFFF, 4'hF, 32'd0);
		add_step(OP_RD, A_OUTSIDE, 32'd0, 4'h0, 32'h0000_0000);
		add_step(OP_RD, A_CTRL, 32'd0, 4'h0, 32'h1234_0001);
		add_step(OP_RD, A_STATUS, 32'd0, 4'h0, 32'h0000_000A);
	endtask

	initial begin
		step_t       s;
		logic [31:0] got;
		aresetn = 1'b0;
		awaddr  = 32'd0;
		awvalid = 1'b0;
		wdata   = 32'd0;
		wstrb   = 4'h0;
		wvalid  = 1'b0;
		bready  = 1'b0; // raised by the bus tasks
		araddr  = 32'd0;
		arvalid = 1'b0;
		rready  = 1'b0;
		t_done  = 1'b0;
		r_done  = 1'b0;
		rx_data = 8'd0;
		errors  = 0;
		hung    = 1'b0;
		build_table();
		repeat (2) @(negedge clk);
		aresetn = 1'b1;

		for (int i = 0; i < steps.size() && !hung; i++) begin
			s = steps[i];
			@(negedge clk);
			case (s.op)
				OP_WR: begin
					bus_write(s.addr, s.data, s.strb);
				end
				OP_RD: begin
					bus_read(s.addr, got);
					if (!hung) begin
						compare_word("s_axi_rdata_o", got, s.exp);
					end
				end
				OP_TX: begin
					compare_word("tx_o", {24'd0, tx_data}, s.exp);
					compare_word("tx_en_o", {31'd0, tx_en}, 32'd1);
					t_done = 1'b1;
					@(negedge clk);
					t_done = 1'b0;
				end
				OP_RX: begin
					rx_data = s.data[7:0];
					r_done  = 1'b1;
					@(negedge clk);
					r_done  = 1'b0;
				end
				default: begin
					compare_word("{tx_en_o, rx_en_o, baud_div_o}",
						{14'd0, tx_en, rx_en, baud_div}, s.exp);
				end
			endcase
		end

		errors += int'(dut0.u_slave.u_asserts.fail_count);
		$display("%0d errors, %0d timeouts, %0d steps", errors, hung, steps.size());
		if (errors == 0 && !hung) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/axi_lite_slave_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_lite_slave_asserts (
	input  logic        clk_i,
	input  logic        aresetn_i,
	input  logic        awready_i,
	input  logic        wready_i,
	input  logic        arready_i,
	input  logic        bvalid_i,
	input  logic        bready_i,
	input  logic        rvalid_i,
	input  logic        rready_i,
	input  logic [31:0] rdata_i
);

	int unsigned fail_count = 0; // summed into the testbench error count

	// write response held until taken
	bresp_hold: assert property (@(posedge clk_i) disable iff (!aresetn_i)
		bvalid_i && !bready_i |=> bvalid_i)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	rresp_hold: assert property (@(posedge clk_i) disable iff (!aresetn_i)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
		else begin
			$error("rvalid or rdata changed before rready");
			fail_count++;
		end

	// second reset cycle on, the slave must be quiet
	no_ready_in_reset: assert property (@(posedge clk_i)
		!aresetn_i && $past(!aresetn_i) |-> !awready_i && !wready_i && !arready_i)
		else begin
			$error("ready high during reset");
			fail_count++;
		end

endmodule

bind axi_lite_slave axi_lite_slave_asserts u_asserts (
	.clk_i     (s_axi_aclk_i),
	.aresetn_i (s_axi_aresetn_i),
	.awready_i (s_axi_awready_o),
	.wready_i  (s_axi_wready_o),
	.arready_i (s_axi_arready_o),
	.bvalid_i  (s_axi_bvalid_o),
	.bready_i  (s_axi_bready_i),
	.rvalid_i  (s_axi_rvalid_o),
	.rready_i  (s_axi_rready_i),
	.rdata_i   (s_axi_rdata_o)
);

`default_nettype wire

// ==== hdl/uart_axi_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_axi_top import uart_axi_pkg::*; #(
	parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
	input  logic        s_axi_aclk_i,
	input  logic        s_axi_aresetn_i,
	// write side
	input  logic [31:0] s_axi_awaddr_i,
	input  logic        s_axi_awvalid_i,
	output logic        s_axi_awready_o,
	input  logic [31:0] s_axi_wdata_i,
	input  logic [3:0]  s_axi_wstrb_i,
	input  logic        s_axi_wvalid_i,
	output logic        s_axi_wready_o,
	output logic        s_axi_bvalid_o,
	input  logic        s_axi_bready_i,
	// read side
	input  logic [31:0] s_axi_araddr_i,
	input  logic        s_axi_arvalid_i,
	output logic        s_axi_arready_o,
	output logic [31:0] s_axi_rdata_o,
	output logic        s_axi_rvalid_o,
	input  logic        s_axi_rready_i,
	// serializer
	input  logic        t_done_i,
	input  logic        r_done_i,
	input  logic [7:0]  rx_i,
	output logic        tx_en_o,
	output logic        rx_en_o,
	output logic [7:0]  tx_o,
	output logic [15:0] baud_div_o
);

	reg_req_t    req;
	logic [31:0] rd_word; // read word for the current request

	logic       tx_push;
	logic       tx_pop;
	logic [7:0] tx_din;
	logic [7:0] tx_head;
	logic       tx_full;
	logic       tx_empty;

	logic       rx_push;
	logic       rx_pop;
	logic [7:0] rx_din;
	logic [7:0] rx_head;
	logic       rx_full;
	logic       rx_empty;

	axi_lite_slave u_slave (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wstrb_i   (s_axi_wstrb_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.req_o           (req),
		.rdata_i         (rd_word)
	);

	uart_regfile u_regfile (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.req_i           (req),
		.rdata_o         (rd_word),
		.t_done_i        (t_done_i),
		.r_done_i        (r_done_i),
		.rx_i            (rx_i),
		.tx_push_o       (tx_push),
		.tx_pop_o        (tx_pop),
		.tx_din_o        (tx_din),
		.tx_head_i       (tx_head),
		.tx_full_i       (tx_full),
		.tx_empty_i      (tx_empty),
		.rx_push_o       (rx_push),
		.rx_pop_o        (rx_pop),
		.rx_din_o        (rx_din),
		.rx_head_i       (rx_head),
		.rx_full_i       (rx_full),
		.rx_empty_i      (rx_empty),
		.tx_en_o         (tx_en_o),
		.rx_en_o         (rx_en_o),
		.tx_o            (tx_o),
		.baud_div_o      (baud_div_o)
	);

	byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo ( // bus to serializer
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.push_i          (tx_push),
		.din_i           (tx_din),
		.pop_i           (tx_pop),
		.head_o          (tx_head),
		.full_o          (tx_full),
		.empty_o         (tx_empty)
	);

	byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo ( // serializer to bus
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.push_i          (rx_push),
		.din_i           (rx_din),
		.pop_i           (rx_pop),
		.head_o          (rx_head),
		.full_o          (rx_full),
		.empty_o         (rx_empty)
	);

endmodule

`default_nettype wire

// ==== hdl/uart_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_regfile import uart_axi_pkg::*; (
	input  logic        s_axi_aclk_i,
	input  logic        s_axi_aresetn_i,
	input  reg_req_t    req_i,
	output logic [31:0] rdata_o,     // for req_i.rd_offset
	input  logic        t_done_i,
	// receive path
	input  logic        r_done_i,
	input  logic [7:0]  rx_i,
	// transmit buffer
	output logic        tx_push_o,
	output logic        tx_pop_o,
	output logic [7:0]  tx_din_o,
	input  logic [7:0]  tx_head_i,
	input  logic        tx_full_i,
	input  logic        tx_empty_i,
	// receive buffer
	output logic        rx_push_o,
	output logic        rx_pop_o,
	output logic [7:0]  rx_din_o,
	input  logic [7:0]  rx_head_i,
	input  logic        rx_full_i,
	input  logic        rx_empty_i,
	// serializer
	output logic        tx_en_o,
	output logic        rx_en_o,
	output logic [7:0]  tx_o,
	output logic [15:0] baud_div_o
);

	ctrl_reg_t    ctrl_q;
	uart_status_t status;
	logic         ctrl_wr;
	logic         wdata_wr;
	logic         rdata_rd;

	assign ctrl_wr  = req_i.wr && (req_i.offset == OFS_CTRL);
	assign wdata_wr = req_i.wr && (req_i.offset == OFS_WDATA);
	assign rdata_rd = req_i.rd && (req_i.rd_offset == OFS_RDATA);

	// byte lanes follow the strobes
	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			ctrl_q <= '0;
		end else if (ctrl_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (req_i.strb[i]) begin
					ctrl_q[8*i +: 8] <= req_i.wdata[8*i +: 8];
				end
			end
		end
	end

	// flags come straight from the buffers
	assign status.rx_empty = rx_empty_i;
	assign status.rx_full  = rx_full_i;
	assign status.tx_empty = tx_empty_i;
	assign status.tx_full  = tx_full_i;

	always_comb begin
		case (req_i.rd_offset)
			OFS_CTRL: begin
				rdata_o = ctrl_q;
			end
			OFS_STATUS: begin
				rdata_o = {28'd0, status};
			end
			OFS_RDATA: begin
				rdata_o = rx_empty_i ? 32'd0 : {24'd0, rx_head_i}; // empty reads as zero
			end
			default: begin
				rdata_o = 32'd0; // wdata and unused offsets
			end
		endcase
	end

	// bus side of the buffers
	assign tx_push_o = wdata_wr & ~tx_full_i; // dropped when full
	assign tx_din_o  = req_i.wdata[7:0];
	assign rx_pop_o  = rdata_rd & ~rx_empty_i;

	// serializer side
	assign tx_en_o    = ctrl_q.tx_en & ~tx_empty_i;
	assign tx_pop_o   = t_done_i & tx_en_o; // one byte per done pulse
	assign rx_en_o    = ctrl_q.rx_en & ~rx_full_i;
	assign rx_push_o  = r_done_i & rx_en_o;
	assign rx_din_o   = rx_i;
	assign tx_o       = tx_head_i; // head shown without a copy
	assign baud_div_o = ctrl_q.baud_div;

endmodule

`default_nettype wire

// ==== axi_lite/axi_lite_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_lite_slave import uart_axi_pkg::*; (
	input  logic        s_axi_aclk_i,
	input  logic        s_axi_aresetn_i,
	// write address, data and response
	input  logic [31:0] s_axi_awaddr_i,
	input  logic        s_axi_awvalid_i,
	output logic        s_axi_awready_o,
	input  logic [31:0] s_axi_wdata_i,
	input  logic [3:0]  s_axi_wstrb_i,
	input  logic        s_axi_wvalid_i,
	output logic        s_axi_wready_o,
	output logic        s_axi_bvalid_o,
	input  logic        s_axi_bready_i,
	// read address and data
	input  logic [31:0] s_axi_araddr_i,
	input  logic        s_axi_arvalid_i,
	output logic        s_axi_arready_o,
	output logic [31:0] s_axi_rdata_o,
	output logic        s_axi_rvalid_o,
	input  logic        s_axi_rready_i,
	// register file
	output reg_req_t    req_o,
	input  logic [31:0] rdata_i
);

	logic        bus_live; // set one cycle after reset release
	logic        b_pend;   // write response outstanding
	logic        r_pend;   // read response outstanding
	logic [31:0] rdata_q;
	logic        aw_hit;
	logic        ar_hit;
	logic        wr_acc;
	logic        rd_acc;

	// readys drop while a response waits for its ready
	assign s_axi_awready_o = bus_live & ~b_pend;
	assign s_axi_wready_o  = bus_live & ~b_pend;
	assign s_axi_arready_o = bus_live & ~r_pend;

	// address and data must come together
	assign wr_acc = s_axi_awvalid_i & s_axi_wvalid_i & s_axi_awready_o;
	assign rd_acc = s_axi_arvalid_i & s_axi_arready_o;

	// window check on the upper address bits
	assign aw_hit = ((s_axi_awaddr_i & ~UART_ADDR_MASK) == UART_BASE_ADDR);
	assign ar_hit = ((s_axi_araddr_i & ~UART_ADDR_MASK) == UART_BASE_ADDR);

	always_comb begin
		req_o.wr        = wr_acc & aw_hit; // outside the window: response only
		req_o.rd        = rd_acc & ar_hit;
		req_o.offset    = s_axi_awaddr_i[3:0];
		req_o.rd_offset = s_axi_araddr_i[3:0];
		req_o.wdata     = s_axi_wdata_i;
		req_o.strb      = s_axi_wstrb_i;
	end

	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			bus_live <= 1'b0;
			b_pend   <= 1'b0;
			r_pend   <= 1'b0;
		end else begin
			bus_live <= 1'b1;
			if (wr_acc) begin
				b_pend <= 1'b1;
			end else if (s_axi_bready_i) begin
				b_pend <= 1'b0; // response taken
			end
			if (rd_acc) begin
				r_pend <= 1'b1;
			end else if (s_axi_rready_i) begin
				r_pend <= 1'b0;
			end
		end
	end

	// read word captured at acceptance, held until rready
	always_ff @(posedge s_axi_aclk_i) begin
		if (rd_acc) begin
			rdata_q <= ar_hit ? rdata_i : 32'd0;
		end
	end

	assign s_axi_bvalid_o = b_pend;
	assign s_axi_rvalid_o = r_pend;
	assign s_axi_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module byte_fifo import uart_axi_pkg::*; #(
	parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH // power of two, at least 2
) (
	input  logic       s_axi_aclk_i,
	input  logic       s_axi_aresetn_i,
	input  logic       push_i,
	input  logic [7:0] din_i,
	input  logic       pop_i,
	output logic [7:0] head_o,
	output logic       full_o,
	output logic       empty_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0]  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr; // extra msb tells full from empty
	logic [AW:0] rd_ptr;
	logic        push_ok;
	logic        pop_ok;

	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]}); // one lap ahead
	assign push_ok = push_i & ~full_o;
	assign pop_ok  = pop_i & ~empty_o;
	assign head_o  = mem[rd_ptr[AW-1:0]]; // fall-through

	always_ff @(posedge s_axi_aclk_i) begin
		if (push_ok) begin
			mem[wr_ptr[AW-1:0]] <= din_i;
		end
	end

	// push and pop in one cycle are both taken
	always_ff @(posedge s_axi_aclk_i) begin
		if (!s_axi_aresetn_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + (AW+1)'(1);
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + (AW+1)'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/uart_axi_pkg.sv ====
`default_nettype none

package uart_axi_pkg;

	// register window on the bus
	localparam logic [31:0] UART_BASE_ADDR = 32'h2000_0000;
	localparam logic [31:0] UART_ADDR_MASK = 32'h0000_000F; // offset bits inside the window

	// word offsets
	localparam logic [3:0] OFS_CTRL   = 4'h0; // read / write
	localparam logic [3:0] OFS_STATUS = 4'h4; // read only
	localparam logic [3:0] OFS_RDATA  = 4'h8; // read pops rx byte
	localparam logic [3:0] OFS_WDATA  = 4'hC; // write pushes tx byte

	// bytes per buffer, power of two
	localparam int DEFAULT_FIFO_DEPTH = 32;

	// control word as seen on the bus
	typedef struct packed {
		logic [15:0] baud_div;
		logic [13:0] reserved; // no function, reads back as written
		logic        rx_en;
		logic        tx_en;
	} ctrl_reg_t;

	// reset value 4'b1010, both buffers empty
	typedef struct packed {
		logic rx_empty;
		logic rx_full;
		logic tx_empty;
		logic tx_full;
	} uart_status_t;

	// one accepted bus access, slave to register file
	// a read and a write can share an edge, so each side has its own offset
	typedef struct packed {
		logic        wr;        // write in window
		logic        rd;        // read in window
		logic [3:0]  offset;    // write offset
		logic [3:0]  rd_offset; // read offset
		logic [31:0] wdata;
		logic [3:0]  strb;
	} reg_req_t;

endpackage

`default_nettype wire
